// File: all.f
hdl/pvt_pkg.sv
hdl/pvt_delay.sv
hdl/pvt_bank.sv
hdl/pvt_init.sv
hdl/pvt_wr_arb.sv
hdl/pvt_rd_merge.sv
hdl/pvt_top.sv
sim/tb_check.sv
sim/tb_top.sv

// File: run.sh
#!/bin/bash
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_top \
  -f all.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -x '>>> PASS' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// File: sim/tb_top.sv
module tb_top;
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic                                  vread;
    pvt_pkg::addr_t                        vaddr;
    logic                                  vwrite;
    pvt_pkg::data_t                        vdin;
    logic [pvt_pkg::num_set-1:0]           vset;
    pvt_pkg::addr_t [pvt_pkg::num_set-1:0] vstaddr;
    pvt_pkg::data_t [pvt_pkg::num_set-1:0] vstin;
    pvt_pkg::data_t                        rd_exp; // what this row's read returns.
  } row_t;

  logic                        clk = 1'b0;
  logic                        rstvld;
  logic                        vread;
  logic                        vwrite;
  pvt_pkg::addr_t              vaddr;
  pvt_pkg::data_t              vdin;
  logic [pvt_pkg::num_set-1:0] vset;
  pvt_pkg::addr_t              vstaddr [pvt_pkg::num_set];
  pvt_pkg::data_t              vstin [pvt_pkg::num_set];
  logic                        vread_vld;
  pvt_pkg::data_t              vdout;
  logic                        vread_fwrd;
  logic                        ready;
  int                          errors;
  int                          reads;
  int                          cycles = 0;
  int                          limit = 1000;
  integer                      seed;
  row_t                        tbl [$];

  always #50 clk = ~clk;

  pvt_top i_pvt_top (
    .clk        (clk),
    .rstvld     (rstvld),
    .vread      (vread),
    .vwrite     (vwrite),
    .vaddr      (vaddr),
    .vdin       (vdin),
    .vset       (vset),
    .vstaddr    (vstaddr),
    .vstin      (vstin),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd),
    .ready      (ready)
  );

  tb_check u_check (
    .clk        (clk),
    .rstvld     (rstvld),
    .ready      (ready),
    .vread      (vread),
    .vwrite     (vwrite),
    .vaddr      (vaddr),
    .vdin       (vdin),
    .vset       (vset),
    .vstaddr    (vstaddr),
    .vstin      (vstin),
    .vread_vld  (vread_vld),
    .vdout      (vdout),
    .vread_fwrd (vread_fwrd),
    .errors     (errors),
    .reads      (reads)
  );

  // nonzero, with room left for the counters.
  function automatic pvt_pkg::data_t rnd_data();
    pvt_pkg::data_t d;
    d = $random(seed);
    return (d & 32'h0fff_ffff) | 32'h0000_0100;
  endfunction

  task automatic add_row(input logic rd, input pvt_pkg::addr_t ra, input logic up,
                         input logic [1:0] st, input pvt_pkg::addr_t sa0,
                         input pvt_pkg::addr_t sa1);
    row_t w;
    w = '0;
    w.vread = rd;
    w.vaddr = ra;
    w.vwrite = up;
    w.vdin = rnd_data();
    w.vset = st;
    w.vstaddr[0] = sa0;
    w.vstaddr[1] = sa1;
    w.vstin[0] = rnd_data();
    w.vstin[1] = rnd_data();
    tbl.push_back(w);
  endtask

  task automatic idle_rows(input int n);
    repeat (n) add_row(1'b0, 0, 1'b0, 2'b00, 0, 0);
  endtask

  task automatic build_table();
    for (int a = 0; a < pvt_pkg::num_addr; a++) begin
      add_row(1'b1, a, 1'b0, 2'b00, 0, 0); // all empty after the sweep.
    end
    for (int i = 0; i < 8; i++) begin
      add_row(1'b0, 0, 1'b0, 2'b11, i, i + 8);
    end
    for (int a = 0; a < 16; a++) begin
      add_row(1'b1, a, 1'b0, 2'b00, 0, 0);
    end
    idle_rows(3);
    // three counters, each read again as its update lands.
    for (int k = 0; k < 8; k++) begin
      add_row(1'b1, 3, 1'b1, 2'b00, 0, 0);
      add_row(1'b1, 9, 1'b1, 2'b00, 0, 0);
      add_row(1'b1, 30, 1'b1, 2'b00, 0, 0);
    end
    repeat (3) add_row(1'b0, 0, 1'b1, 2'b00, 0, 0);
    add_row(1'b1, 9, 1'b0, 2'b00, 0, 0);
    idle_rows(2);
    add_row(1'b0, 0, 1'b1, 2'b11, 40, 41); // update and both sets together.
    add_row(1'b0, 0, 1'b0, 2'b11, 42, 42);
    idle_rows(2);
    add_row(1'b1, 9, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 40, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 41, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 42, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 48, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 63, 1'b0, 2'b00, 0, 0);
    add_row(1'b0, 0, 1'b0, 2'b11, 50, 60);
    repeat (3) add_row(1'b0, 0, 1'b1, 2'b00, 0, 0); // no read behind these.
    add_row(1'b1, 44, 1'b0, 2'b01, 44, 0);
    add_row(1'b1, 45, 1'b0, 2'b10, 0, 45);
    idle_rows(2);
    add_row(1'b1, 44, 1'b0, 2'b00, 0, 0);
    add_row(1'b1, 45, 1'b0, 2'b00, 0, 0);
    for (int a = 0; a < pvt_pkg::num_addr; a++) begin
      add_row(1'b1, a, 1'b0, 2'b00, 0, 0);
    end
  endtask

  // fills in update data and expected read values, row by row.
  task automatic predict_reads();
    pvt_pkg::data_t mem [pvt_pkg::num_addr];
    row_t           w;
    row_t           src;
    for (int a = 0; a < pvt_pkg::num_addr; a++) begin
      mem[a] = '0;
    end
    for (int r = 0; r <= tbl.size(); r++) begin
      if (r < tbl.size()) begin
        w = tbl[r];
        if (w.vwrite && (r >= 3)) begin
          src = tbl[r-3];
          if (src.vread && (src.vaddr < pvt_pkg::num_addr)) begin
            w.vdin = src.rd_exp + 1;
            mem[src.vaddr] = w.vdin;
          end
        end
        for (int i = 0; i < pvt_pkg::num_set; i++) begin
          if (w.vset[i] && (w.vstaddr[i] < pvt_pkg::num_addr)) begin
            mem[w.vstaddr[i]] = w.vstin[i]; // port 1 lands last.
          end
        end
        tbl[r] = w;
      end
      if (r > 0) begin
        w = tbl[r-1];
        w.rd_exp = (w.vaddr < pvt_pkg::num_addr) ? mem[w.vaddr] : '0;
        tbl[r-1] = w;
      end
    end
  endtask

  task automatic drive_row(input row_t w);
    vread <= w.vread;
    vaddr <= w.vaddr;
    vwrite <= w.vwrite;
    vdin <= w.vdin;
    vset <= w.vset;
    for (int i = 0; i < pvt_pkg::num_set; i++) begin
      vstaddr[i] <= w.vstaddr[i];
      vstin[i] <= w.vstin[i];
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display(">>> FAIL");
      $finish;
    end
  end

  initial begin
    seed = 32'h88646fed;
    rstvld = 1'b1;
    drive_row('0);
    build_table();
    predict_reads();
    limit = 10 + pvt_pkg::num_addr + 10 + tbl.size() + 20;
    repeat (10) @(posedge clk);
    rstvld <= 1'b0;
    while (!ready) @(negedge clk);
    foreach (tbl[r]) begin
      @(posedge clk);
      drive_row(tbl[r]);
    end
    @(posedge clk);
    drive_row('0);
    repeat (4) @(posedge clk); // last reads drain.
    @(negedge clk);
    $display("rows %0d, reads checked %0d, errors %0d", tbl.size(), reads, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// File: sim/tb_check.sv
module tb_check (
  input  logic                        clk,
  input  logic                        rstvld,
  input  logic                        ready,
  input  logic                        vread,
  input  logic                        vwrite,
  input  pvt_pkg::addr_t              vaddr,
  input  pvt_pkg::data_t              vdin,
  input  logic [pvt_pkg::num_set-1:0] vset,
  input  pvt_pkg::addr_t              vstaddr [pvt_pkg::num_set],
  input  pvt_pkg::data_t              vstin [pvt_pkg::num_set],
  input  logic                        vread_vld,
  input  pvt_pkg::data_t              vdout,
  input  logic                        vread_fwrd,
  output int                          errors,
  output int                          reads
);
  timeunit 1ns;
  timeprecision 1ps;

  typedef struct packed {
    logic           vld;
    pvt_pkg::addr_t addr;
    logic           fwd;
  } flight_t;

  pvt_pkg::data_t model [pvt_pkg::num_addr]; // one value per address.
  flight_t        hist [4];                  // hist[k] issued k cycles ago.
  int             err_cnt = 0;
  int             rd_cnt = 0;
  int             rel_cnt = 0;               // falling edges since reset release.
  logic           rdy_exp = 1'b0;

  assign errors = err_cnt;
  assign reads = rd_cnt;

  initial begin
    for (int a = 0; a < pvt_pkg::num_addr; a++) begin
      model[a] = '0;
    end
    for (int k = 0; k < 4; k++) begin
      hist[k] = '0;
    end
  end

  // inputs and outputs are both settled at the falling edge.
  always @(negedge clk) begin
    logic           wv [pvt_pkg::num_bank];
    pvt_pkg::addr_t wa [pvt_pkg::num_bank];
    if (!rstvld) begin
      rel_cnt = rel_cnt + 1;
      // held low by the synchronizer, the sweep and one cycle more.
      rdy_exp = (rel_cnt > 3 + pvt_pkg::num_addr + 1);
      if (ready !== rdy_exp) begin
        $display("Error ready exp %h got %h", rdy_exp, ready);
        err_cnt = err_cnt + 1;
      end

      for (int k = 3; k > 0; k--) begin
        hist[k] = hist[k-1];
      end
      hist[0] = '{vld: vread && rdy_exp && (vaddr < pvt_pkg::num_addr),
                  addr: vaddr, fwd: 1'b0};

      // result of the read from two cycles back.
      if (vread_vld !== hist[2].vld) begin
        if (hist[2].vld) begin
          $display("read of address %0d at %0t never raised vread_vld", hist[2].addr, $time);
        end else begin
          $display("vread_vld went high at %0t with no read in flight", $time);
        end
        err_cnt = err_cnt + 1;
      end else if (hist[2].vld) begin
        rd_cnt = rd_cnt + 1;
        if (vdout !== model[hist[2].addr]) begin
          $display("Error vdout exp %h got %h (address %h)", model[hist[2].addr], vdout,
                   hist[2].addr);
          err_cnt = err_cnt + 1;
        end
        if (vread_fwrd !== hist[2].fwd) begin
          $display("Error vread_fwrd exp %h got %h (address %h)", hist[2].fwd, vread_fwrd,
                   hist[2].addr);
          err_cnt = err_cnt + 1;
        end
      end

      wv[0] = vwrite && rdy_exp && hist[3].vld; // update for the read 3 cycles back.
      wa[0] = hist[3].addr;
      if (wv[0]) begin
        model[wa[0]] = vdin;
      end
      for (int i = 0; i < pvt_pkg::num_set; i++) begin
        wv[i+1] = vset[i] && rdy_exp && (vstaddr[i] < pvt_pkg::num_addr);
        wa[i+1] = vstaddr[i];
        if (wv[i+1]) begin
          model[wa[i+1]] = vstin[i];
        end
      end

      // reads still inside the bank latency.
      for (int w = 0; w < pvt_pkg::num_bank; w++) begin
        for (int k = 0; k < 2; k++) begin
          if (wv[w] && hist[k].vld && (hist[k].addr == wa[w])) begin
            hist[k].fwd = 1'b1;
          end
        end
      end
    end else begin
      rel_cnt = 0;
    end
  end

endmodule

// File: hdl/pvt_top.sv
module pvt_top (
  input  logic                        clk,
  input  logic                        rstvld,
  input  logic                        vread,
  input  logic                        vwrite,
  input  pvt_pkg::addr_t              vaddr,
  input  pvt_pkg::data_t              vdin,
  input  logic [pvt_pkg::num_set-1:0] vset,
  input  pvt_pkg::addr_t              vstaddr [pvt_pkg::num_set],
  input  pvt_pkg::data_t              vstin [pvt_pkg::num_set],
  output logic                        vread_vld,
  output pvt_pkg::data_t              vdout,
  output logic                        vread_fwrd,
  output logic                        ready
);

  logic                  sweep_vld;
  pvt_pkg::addr_t        sweep_addr;
  logic                  vwrite_g;
  pvt_pkg::pvt_rd_req_t  rd_req;
  pvt_pkg::pvt_rd_req_t  upd_req;
  pvt_pkg::bank_t        upd_bank;
  pvt_pkg::pvt_set_t     sets [pvt_pkg::num_set];
  pvt_pkg::pvt_bank_wr_t bank_wr [pvt_pkg::num_bank];
  pvt_pkg::data_t        rd_data [pvt_pkg::num_bank];
  pvt_pkg::pvt_rd_rsp_t  rsp;

  pvt_init u_init (
    .clk        (clk),
    .rstvld     (rstvld),
    .sweep_vld  (sweep_vld),
    .sweep_addr (sweep_addr),
    .ready      (ready)
  );

  // out of range addresses are ignored.
  assign rd_req = '{vld: vread && ready && (vaddr < pvt_pkg::num_addr), addr: vaddr};
  assign vwrite_g = vwrite && ready;

  always_comb begin
    for (int i = 0; i < pvt_pkg::num_set; i++) begin
      sets[i].vld = vset[i] && ready && (vstaddr[i] < pvt_pkg::num_addr);
      sets[i].addr = vstaddr[i];
      sets[i].data = vstin[i];
    end
  end

  for (genvar b = 0; b < pvt_pkg::num_bank; b++) begin : g_bank
    pvt_bank u_bank (
      .clk     (clk),
      .wr      (bank_wr[b]),
      .rd_en   (rd_req.vld),
      .rd_addr (rd_req.addr),
      .rd_data (rd_data[b])
    );
  end

  // lines the read up with its update write.
  pvt_delay #(
    .depth     (pvt_pkg::sram_delay + pvt_pkg::updt_delay),
    .payload_t (pvt_pkg::pvt_rd_req_t)
  ) u_req_dly (
    .clk    (clk),
    .rstvld (rstvld),
    .din    (rd_req),
    .dout   (upd_req)
  );

  pvt_delay #(
    .depth     (pvt_pkg::updt_delay),
    .payload_t (pvt_pkg::bank_t)
  ) u_bank_dly (
    .clk    (clk),
    .rstvld (rstvld),
    .din    (rsp.bank),
    .dout   (upd_bank)
  );

  pvt_wr_arb u_wr_arb (
    .clk        (clk),
    .upd        (upd_req),
    .upd_bank   (upd_bank),
    .vwrite     (vwrite_g),
    .vdin       (vdin),
    .sets       (sets),
    .sweep_vld  (sweep_vld),
    .sweep_addr (sweep_addr),
    .bank_wr    (bank_wr)
  );

  pvt_rd_merge u_rd_merge (
    .clk     (clk),
    .rstvld  (rstvld),
    .req     (rd_req),
    .bank_wr (bank_wr),
    .rd_data (rd_data),
    .rsp     (rsp)
  );

  assign vread_vld = rsp.vld;
  assign vdout = rsp.data;
  assign vread_fwrd = rsp.fwrd;

endmodule

// File: hdl/pvt_rd_merge.sv
module pvt_rd_merge (
  input  logic                  clk,
  input  logic                  rstvld,
  input  pvt_pkg::pvt_rd_req_t  req,
  input  pvt_pkg::pvt_bank_wr_t bank_wr [pvt_pkg::num_bank],
  input  pvt_pkg::data_t        rd_data [pvt_pkg::num_bank],
  output pvt_pkg::pvt_rd_rsp_t  rsp
);

  logic [pvt_pkg::sram_delay-1:0] vld_q;
  pvt_pkg::addr_t                 addr_q [pvt_pkg::sram_delay];
  logic [pvt_pkg::num_bank-1:0]   fwd_q [pvt_pkg::sram_delay];
  pvt_pkg::data_t                 fwd_data_q [pvt_pkg::sram_delay][pvt_pkg::num_bank];

  logic                           src_vld [pvt_pkg::sram_delay];
  pvt_pkg::addr_t                 src_addr [pvt_pkg::sram_delay];
  logic [pvt_pkg::num_bank-1:0]   src_fwd [pvt_pkg::sram_delay];
  pvt_pkg::data_t                 src_data [pvt_pkg::sram_delay][pvt_pkg::num_bank];
  logic [pvt_pkg::num_bank-1:0]   hit [pvt_pkg::sram_delay];

  pvt_pkg::data_t                 sel_data [pvt_pkg::num_bank];
  logic [pvt_pkg::num_bank-1:0]   nz;

  // input of each stage, and writes that hit it this cycle.
  always_comb begin
    for (int s = 0; s < pvt_pkg::sram_delay; s++) begin
      src_vld[s] = (s == 0) ? req.vld : vld_q[(s == 0) ? 0 : s - 1];
      src_addr[s] = (s == 0) ? req.addr : addr_q[(s == 0) ? 0 : s - 1];
      src_fwd[s] = (s == 0) ? '0 : fwd_q[(s == 0) ? 0 : s - 1];
      for (int b = 0; b < pvt_pkg::num_bank; b++) begin
        src_data[s][b] = (s == 0) ? '0 : fwd_data_q[(s == 0) ? 0 : s - 1][b];
        hit[s][b] = src_vld[s] && bank_wr[b].en && (bank_wr[b].addr == src_addr[s]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rstvld) begin
      vld_q <= '0;
      for (int s = 0; s < pvt_pkg::sram_delay; s++) begin
        fwd_q[s] <= '0;
      end
    end else begin
      for (int s = 0; s < pvt_pkg::sram_delay; s++) begin
        vld_q[s] <= src_vld[s];
        fwd_q[s] <= src_fwd[s] | hit[s];
      end
    end
  end

  // later write overrides the earlier one.
  always_ff @(posedge clk) begin
    for (int s = 0; s < pvt_pkg::sram_delay; s++) begin
      addr_q[s] <= src_addr[s];
      for (int b = 0; b < pvt_pkg::num_bank; b++) begin
        fwd_data_q[s][b] <= hit[s][b] ? bank_wr[b].data : src_data[s][b];
      end
    end
  end

  always_comb begin
    rsp = '0;
    rsp.vld = vld_q[pvt_pkg::sram_delay-1];
    rsp.fwrd = vld_q[pvt_pkg::sram_delay-1] && (|fwd_q[pvt_pkg::sram_delay-1]);
    for (int b = 0; b < pvt_pkg::num_bank; b++) begin
      sel_data[b] = fwd_q[pvt_pkg::sram_delay-1][b] ?
                    fwd_data_q[pvt_pkg::sram_delay-1][b] : rd_data[b];
      nz[b] = |sel_data[b];
      if (nz[b]) begin
        rsp.data = sel_data[b]; // highest nonzero bank wins.
        rsp.bank = pvt_pkg::bank_t'(b);
      end
    end
  end

  a_one_pivot: assert property (@(posedge clk) disable iff (rstvld)
    rsp.vld |-> $onehot0(nz))
    else $error("value found in more than one bank");

endmodule

// File: hdl/pvt_wr_arb.sv
module pvt_wr_arb (
  input  logic                  clk,
  input  pvt_pkg::pvt_rd_req_t  upd,
  input  pvt_pkg::bank_t        upd_bank,
  input  logic                  vwrite,
  input  pvt_pkg::data_t        vdin,
  input  pvt_pkg::pvt_set_t     sets [pvt_pkg::num_set],
  input  logic                  sweep_vld,
  input  pvt_pkg::addr_t        sweep_addr,
  output pvt_pkg::pvt_bank_wr_t bank_wr [pvt_pkg::num_bank]
);

  logic                          upd_go;
  logic [pvt_pkg::num_set-1:0]   set_ok;
  logic [pvt_pkg::num_set-1:0]   set_placed;
  logic [pvt_pkg::num_bank-1:0]  taken;
  logic [pvt_pkg::num_bank-1:0]  wr_en;
  int                            want;
  logic                          clash;

  assign upd_go = upd.vld && vwrite; // update without a read is dropped.

  // higher port wins on a shared address.
  always_comb begin
    for (int i = 0; i < pvt_pkg::num_set; i++) begin
      set_ok[i] = sets[i].vld;
      for (int j = i + 1; j < pvt_pkg::num_set; j++) begin
        if (sets[j].vld && (sets[j].addr == sets[i].addr)) begin
          set_ok[i] = 1'b0;
        end
      end
    end
  end

  always_comb begin
    taken = '0;
    for (int b = 0; b < pvt_pkg::num_bank; b++) begin
      bank_wr[b] = '0;
      if (upd_go && (upd_bank == b)) begin
        bank_wr[b] = '{en: 1'b1, addr: upd.addr, data: vdin};
        taken[b] = 1'b1;
      end
    end
    // sets fill the lowest free banks.
    for (int i = 0; i < pvt_pkg::num_set; i++) begin
      set_placed[i] = 1'b0;
      for (int b = 0; b < pvt_pkg::num_bank; b++) begin
        if (set_ok[i] && !set_placed[i] && !taken[b]) begin
          bank_wr[b] = '{en: 1'b1, addr: sets[i].addr, data: sets[i].data};
          taken[b] = 1'b1;
          set_placed[i] = 1'b1;
        end
      end
    end
    if (sweep_vld) begin
      for (int b = 0; b < pvt_pkg::num_bank; b++) begin
        bank_wr[b] = '{en: 1'b1, addr: sweep_addr, data: '0};
      end
    end
  end

  // every writer asked for needs a bank enable of its own.
  always_comb begin
    want = int'(upd_go);
    for (int i = 0; i < pvt_pkg::num_set; i++) begin
      want = want + int'(set_ok[i]);
    end
    for (int b = 0; b < pvt_pkg::num_bank; b++) begin
      wr_en[b] = bank_wr[b].en;
    end
    clash = ($countones(wr_en) != want);
  end

  a_one_writer: assert property (@(posedge clk) !sweep_vld |-> !clash)
    else $error("two writers on one bank");

endmodule

// File: hdl/pvt_init.sv
module pvt_init (
  input  logic           clk,
  input  logic           rstvld,
  output logic           sweep_vld,
  output pvt_pkg::addr_t sweep_addr,
  output logic           ready
);

  logic [2:0]                   rst_q;
  logic                         rst_sync;
  logic [pvt_pkg::addr_bits:0]  sweep_cnt; // one extra bit to pass num_addr.

  always_ff @(posedge clk) begin
    rst_q <= {rst_q[1:0], rstvld};
  end

  assign rst_sync = rst_q[2];

  assign sweep_vld = !rst_sync && (sweep_cnt < pvt_pkg::num_addr);
  assign sweep_addr = sweep_cnt[pvt_pkg::addr_bits-1:0];

  always_ff @(posedge clk) begin
    if (rst_sync) begin
      sweep_cnt <= '0;
    end else if (sweep_vld) begin
      sweep_cnt <= sweep_cnt + 1'b1;
    end
  end

  // high one cycle after the last cleared address.
  always_ff @(posedge clk) begin
    if (rst_sync) begin
      ready <= 1'b0;
    end else begin
      ready <= !sweep_vld;
    end
  end

  a_ready_sweep: assert property (@(posedge clk) disable iff (rstvld)
    !(ready && sweep_vld))
    else $error("ready high during sweep");

endmodule

// File: hdl/pvt_bank.sv
module pvt_bank (
  input  logic                  clk,
  input  pvt_pkg::pvt_bank_wr_t wr,
  input  logic                  rd_en,
  input  pvt_pkg::addr_t        rd_addr,
  output pvt_pkg::data_t        rd_data
);

  pvt_pkg::data_t mem [pvt_pkg::num_addr];
  pvt_pkg::data_t rd_q [pvt_pkg::sram_delay];

  // write lands at the edge.
  always_ff @(posedge clk) begin
    if (wr.en) begin
      mem[wr.addr] <= wr.data;
    end
  end

  // models the sram read latency.
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_q[0] <= mem[rd_addr]; // sees old content on a same-cycle write.
    end
    for (int s = 1; s < pvt_pkg::sram_delay; s++) begin
      rd_q[s] <= rd_q[s-1];
    end
  end

  assign rd_data = rd_q[pvt_pkg::sram_delay-1];

endmodule

// File: hdl/pvt_delay.sv
module pvt_delay #(
  parameter int  depth = 1,
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rstvld,
  input  payload_t din,
  output payload_t dout
);

  payload_t pipe [depth];

  always_ff @(posedge clk) begin
    if (rstvld) begin
      for (int i = 0; i < depth; i++) begin
        pipe[i] <= '0;
      end
    end else begin
      pipe[0] <= din;
      for (int i = 1; i < depth; i++) begin
        pipe[i] <= pipe[i-1];
      end
    end
  end

  assign dout = pipe[depth-1];

endmodule

// File: hdl/pvt_pkg.sv
package pvt_pkg;

  localparam int width = 32;
  localparam int num_addr = 48;
  localparam int addr_bits = 6;
  localparam int num_set = 2;
  localparam int num_bank = num_set + 1; // one update plus every set.
  localparam int bank_bits = 2;
  localparam int sram_delay = 2;
  localparam int updt_delay = 1;

  typedef logic [width-1:0] data_t;
  typedef logic [addr_bits-1:0] addr_t;
  typedef logic [bank_bits-1:0] bank_t;

  // read request, 7 bits.
  typedef struct packed {
    logic  vld;
    addr_t addr;
  } pvt_rd_req_t;

  // one set port, 39 bits.
  typedef struct packed {
    logic  vld;
    addr_t addr;
    data_t data;
  } pvt_set_t;

  // one bank write port, 39 bits.
  typedef struct packed {
    logic  en;
    addr_t addr;
    data_t data;
  } pvt_bank_wr_t;

  // read result, 36 bits.
  typedef struct packed {
    logic  vld;
    data_t data;
    logic  fwrd;
    bank_t bank; // bank that held the value.
  } pvt_rd_rsp_t;

endpackage
